//--- common/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath and instruction width
`define XLEN 32

// Word counts
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64
`define REG_COUNT 32

`endif

//--- common/mipsPkg.sv
package mipsPkg;

	////////////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////////////

	// Supported primary opcodes
	typedef enum logic [5:0] {
		RTYPE = 6'b000000,
		LW    = 6'b100011,
		SW    = 6'b101011,
		BNE   = 6'b000101,
		J     = 6'b000010,
		ADDI  = 6'b001000
	} opcodeT;

	// R-type funct codes
	typedef enum logic [5:0] {
		FN_ADD = 6'b100000,
		FN_SUB = 6'b100010,
		FN_AND = 6'b100100,
		FN_OR  = 6'b100101,
		FN_SLT = 6'b101010
	} functT;

	////////////////////////////////////////////////////////////////////
	// ALU selection
	////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ADD_CLASS   = 2'b00,	// Address calc, addi
		SUB_CLASS   = 2'b01,	// bne compare
		FUNCT_CLASS = 2'b10	// Look at funct
	} aluOpT;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT} aluCtrlT;

endpackage

//--- control/mainControl.sv
module mainControl (
	input  mipsPkg::opcodeT opcode,	// Instr [31:26]
	output logic regDst,
	output logic aluSrc,
	output logic memToReg,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic branch,
	output mipsPkg::aluOpT aluOp,
	output logic flushControl,		// Squash younger instr
	output logic nextPcControl		// Take jump target
);

	always_comb begin
		// Default is a no-op, also covers unknown opcodes
		regDst        = 1'b0;
		aluSrc        = 1'b0;
		memToReg      = 1'b0;
		regWrite      = 1'b0;
		memRead       = 1'b0;
		memWrite      = 1'b0;
		branch        = 1'b0;
		aluOp         = mipsPkg::ADD_CLASS;
		flushControl  = 1'b0;
		nextPcControl = 1'b0;
		case (opcode)
			mipsPkg::RTYPE: begin
				regDst   = 1'b1;	// Dest in rd
				regWrite = 1'b1;
				aluOp    = mipsPkg::FUNCT_CLASS;
			end
			mipsPkg::LW: begin
				aluSrc   = 1'b1;	// Base + offset
				memToReg = 1'b1;
				regWrite = 1'b1;
				memRead  = 1'b1;
			end
			mipsPkg::SW: begin
				aluSrc   = 1'b1;
				memWrite = 1'b1;
			end
			mipsPkg::BNE: begin
				branch = 1'b1;
				aluOp  = mipsPkg::SUB_CLASS;	// Compare by subtract
			end
			mipsPkg::J: begin
				flushControl  = 1'b1;
				nextPcControl = 1'b1;
			end
			mipsPkg::ADDI: begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;	// Dest in rt
			end
			default: ;	// Unknown, stays a bubble
		endcase
	end

endmodule

//--- control/aluControl.sv
module aluControl (
	input  mipsPkg::aluOpT aluOp,
	input  logic [5:0] funct,
	output mipsPkg::aluCtrlT aluCtrl
);

	mipsPkg::functT fn;

	assign fn = mipsPkg::functT'(funct);

	always_comb begin
		case (aluOp)
			mipsPkg::ADD_CLASS: aluCtrl = mipsPkg::ADD;
			mipsPkg::SUB_CLASS: aluCtrl = mipsPkg::SUB;
			mipsPkg::FUNCT_CLASS: begin
				case (fn)
					mipsPkg::FN_SUB: aluCtrl = mipsPkg::SUB;
					mipsPkg::FN_AND: aluCtrl = mipsPkg::AND;
					mipsPkg::FN_OR:  aluCtrl = mipsPkg::OR;
					mipsPkg::FN_SLT: aluCtrl = mipsPkg::SLT;
					default:         aluCtrl = mipsPkg::ADD;	// add and unknown funct
				endcase
			end
			default: aluCtrl = mipsPkg::ADD;
		endcase
	end

endmodule

//--- verilog/fetchStage.sv
`include "mips_cfg.svh"

module fetchStage (
	input  logic clk,
	input  logic rstN,
	input  logic run,
	input  logic stall,
	input  logic imemWe,
	input  logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr,	// Word address
	input  logic [`XLEN-1:0] imemData,
	input  logic jumpTaken,
	input  logic [`XLEN-1:0] jumpTarget,
	input  logic branchTaken,
	input  logic [`XLEN-1:0] branchTarget,
	output logic [`XLEN-1:0] instrD,
	output logic [`XLEN-1:0] pcPlus4D,
	output logic validD
);

	localparam int ImemAw = $clog2(`IMEM_DEPTH);

	logic [`XLEN-1:0] imem [`IMEM_DEPTH];
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] pcPlus4;

	assign pcPlus4 = pc + `XLEN'(4);

	// Program load, only while halted
	always_ff @(posedge clk) begin
		if (imemWe && !run)
			imem[imemAddr] <= imemData;
	end

	// Branch wins over jump, either wins over stall
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc     <= '0;
			validD <= 1'b0;
		end else if (branchTaken) begin
			pc     <= branchTarget;
			validD <= 1'b0;	// Squash wrong-path fetch
		end else if (jumpTaken) begin
			pc     <= jumpTarget;
			validD <= 1'b0;
		end else if (!stall) begin
			if (run)
				pc <= pcPlus4;
			validD <= run;
		end
	end

	// Fetch/decode payload
	always_ff @(posedge clk) begin
		if (!stall) begin
			instrD   <= imem[pc[ImemAw+1:2]];
			pcPlus4D <= pcPlus4;
		end
	end

endmodule

//--- verilog/decodeStage.sv
`include "mips_cfg.svh"

module decodeStage (
	input  logic clk,
	input  logic rstN,
	input  logic [`XLEN-1:0] instrD,
	input  logic [`XLEN-1:0] pcPlus4D,
	input  logic validD,
	input  logic branchTaken,
	input  logic wbValid,
	input  logic [4:0] wbReg,
	input  logic [`XLEN-1:0] wbData,
	output logic stall,
	output logic jumpTaken,
	output logic [`XLEN-1:0] jumpTarget,
	output logic regDstE,
	output logic aluSrcE,
	output logic memToRegE,
	output logic regWriteE,
	output logic memReadE,
	output logic memWriteE,
	output logic branchE,
	output mipsPkg::aluOpT aluOpE,
	output logic [`XLEN-1:0] rsDataE,
	output logic [`XLEN-1:0] rtDataE,
	output logic [`XLEN-1:0] immE,
	output logic [4:0] rsE,
	output logic [4:0] rtE,
	output logic [4:0] rdE,
	output logic [5:0] functE,
	output logic [`XLEN-1:0] pcPlus4E,
	output logic validE
);

	logic [`XLEN-1:0] rf [`REG_COUNT];
	logic [4:0] rs, rt, rd;
	logic regDst, aluSrc, memToReg, regWrite, memRead, memWrite, branch;
	logic flushControl, nextPcControl;
	logic bubble;
	mipsPkg::aluOpT aluOp;

	// Write-through read, r0 hardwired
	function automatic logic [`XLEN-1:0] readReg(input logic [4:0] idx);
		if (idx == 5'd0)
			return '0;
		if (wbValid && wbReg == idx)
			return wbData;	// Same-cycle write is visible
		return rf[idx];
	endfunction

	assign rs = instrD[25:21];
	assign rt = instrD[20:16];
	assign rd = instrD[15:11];

	mainControl mainControl_inst (
		.opcode(mipsPkg::opcodeT'(instrD[31:26])),
		.regDst(regDst),
		.aluSrc(aluSrc),
		.memToReg(memToReg),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.branch(branch),
		.aluOp(aluOp),
		.flushControl(flushControl),
		.nextPcControl(nextPcControl)
	);

	always_ff @(posedge clk) begin
		if (wbValid)
			rf[wbReg] <= wbData;
	end

	////////////////////////////////////////////////////////////////////
	// Hazards and redirect
	////////////////////////////////////////////////////////////////////

	// Load in execute feeding this instr
	assign stall = validD && validE && memReadE && rtE != 5'd0 && (rtE == rs || rtE == rt);
	assign jumpTaken = validD && flushControl;
	assign jumpTarget = nextPcControl ? {pcPlus4D[31:28], instrD[25:0], 2'b00} : pcPlus4D;
	assign bubble = !validD || stall || branchTaken;

	// Decode/execute control, cleared on bubble
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validE    <= 1'b0;
			regDstE   <= 1'b0;
			aluSrcE   <= 1'b0;
			memToRegE <= 1'b0;
			regWriteE <= 1'b0;
			memReadE  <= 1'b0;
			memWriteE <= 1'b0;
			branchE   <= 1'b0;
			aluOpE    <= mipsPkg::ADD_CLASS;
		end else begin
			validE    <= !bubble;
			regDstE   <= regDst;
			aluSrcE   <= aluSrc;
			memToRegE <= memToReg;
			regWriteE <= regWrite && !bubble;
			memReadE  <= memRead && !bubble;
			memWriteE <= memWrite && !bubble;
			branchE   <= branch && !bubble;
			aluOpE    <= aluOp;
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		rsDataE  <= readReg(rs);
		rtDataE  <= readReg(rt);
		immE     <= {{(`XLEN-16){instrD[15]}}, instrD[15:0]};	// Sign extend
		rsE      <= rs;
		rtE      <= rt;
		rdE      <= rd;
		functE   <= instrD[5:0];
		pcPlus4E <= pcPlus4D;
	end

endmodule

//--- verilog/executeStage.sv
`include "mips_cfg.svh"

module executeStage (
	input  logic clk,
	input  logic rstN,
	input  logic regDstE,
	input  logic aluSrcE,
	input  logic memToRegE,
	input  logic regWriteE,
	input  logic memReadE,
	input  logic memWriteE,
	input  logic branchE,
	input  mipsPkg::aluOpT aluOpE,
	input  logic [`XLEN-1:0] rsDataE,
	input  logic [`XLEN-1:0] rtDataE,
	input  logic [`XLEN-1:0] immE,
	input  logic [4:0] rsE,
	input  logic [4:0] rtE,
	input  logic [4:0] rdE,
	input  logic [5:0] functE,
	input  logic [`XLEN-1:0] pcPlus4E,
	input  logic validE,
	input  logic fwdMemValid,
	input  logic [4:0] fwdMemReg,
	input  logic [`XLEN-1:0] fwdMemData,
	input  logic wbValid,
	input  logic [4:0] wbReg,
	input  logic [`XLEN-1:0] wbData,
	output logic branchTaken,
	output logic [`XLEN-1:0] branchTarget,
	output logic validM,
	output logic regWriteM,
	output logic memToRegM,
	output logic memReadM,
	output logic memWriteM,
	output logic [`XLEN-1:0] aluResultM,
	output logic [`XLEN-1:0] storeDataM,
	output logic [4:0] writeRegM
);

	logic [`XLEN-1:0] opA, opB, aluB, aluResult;
	mipsPkg::aluCtrlT aluCtrl;

	// Memory stage ahead of write-back and r0 never forwarded
	function automatic logic [`XLEN-1:0] fwd(input logic [4:0] idx,
		input logic [`XLEN-1:0] rfData);
		if (idx == 5'd0)
			return rfData;
		if (fwdMemValid && fwdMemReg == idx)
			return fwdMemData;
		if (wbValid && wbReg == idx)
			return wbData;
		return rfData;
	endfunction

	assign opA  = fwd(rsE, rsDataE);
	assign opB  = fwd(rtE, rtDataE);	// Also store data
	assign aluB = aluSrcE ? immE : opB;

	aluControl aluControl_inst (
		.aluOp(aluOpE),
		.funct(functE),
		.aluCtrl(aluCtrl)
	);

	always_comb begin
		case (aluCtrl)
			mipsPkg::SUB: aluResult = opA - aluB;
			mipsPkg::AND: aluResult = opA & aluB;
			mipsPkg::OR:  aluResult = opA | aluB;
			mipsPkg::SLT: aluResult = `XLEN'($signed(opA) < $signed(aluB));
			default:      aluResult = opA + aluB;
		endcase
	end

	// bne taken on nonzero difference
	assign branchTaken  = branchE && aluResult != '0;
	assign branchTarget = pcPlus4E + {immE[`XLEN-3:0], 2'b00};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validM    <= 1'b0;
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memReadM  <= 1'b0;
			memWriteM <= 1'b0;
		end else begin
			validM    <= validE;
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memReadM  <= memReadE;
			memWriteM <= memWriteE;
		end
	end

	always_ff @(posedge clk) begin
		aluResultM <= aluResult;
		storeDataM <= opB;
		writeRegM  <= regDstE ? rdE : rtE;
	end

endmodule

//--- verilog/memStage.sv
`include "mips_cfg.svh"

module memStage (
	input  logic clk,
	input  logic rstN,
	input  logic validM,
	input  logic regWriteM,
	input  logic memToRegM,
	input  logic memReadM,
	input  logic memWriteM,
	input  logic [`XLEN-1:0] aluResultM,	// Byte address or result
	input  logic [`XLEN-1:0] storeDataM,
	input  logic [4:0] writeRegM,
	output logic fwdMemValid,
	output logic [4:0] fwdMemReg,
	output logic [`XLEN-1:0] fwdMemData,
	output logic wbValid,
	output logic [4:0] wbReg,
	output logic [`XLEN-1:0] wbData,
	output logic memWrValid,
	output logic [`XLEN-1:0] memWrAddr,
	output logic [`XLEN-1:0] memWrData
);

	localparam int DmemAw = $clog2(`DMEM_DEPTH);

	logic [`XLEN-1:0] dmem [`DMEM_DEPTH];
	logic [DmemAw-1:0] wordAddr;

	assign wordAddr = aluResultM[DmemAw+1:2];

	// Load data not ready yet, so loads are not forwarded from here
	assign fwdMemValid = validM && regWriteM && !memReadM;
	assign fwdMemReg   = writeRegM;
	assign fwdMemData  = aluResultM;

	// Store trace
	assign memWrValid = validM && memWriteM;
	assign memWrAddr  = aluResultM;
	assign memWrData  = storeDataM;

	always_ff @(posedge clk) begin
		if (memWrValid)
			dmem[wordAddr] <= storeDataM;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			wbValid <= 1'b0;
		else
			wbValid <= validM && regWriteM && writeRegM != 5'd0;	// r0 writes dropped
	end

	always_ff @(posedge clk) begin
		wbReg  <= writeRegM;
		wbData <= memToRegM ? dmem[wordAddr] : aluResultM;
	end

endmodule

//--- verilog/mipsCore.sv
`include "mips_cfg.svh"

module mipsCore (
	input  logic clk,
	input  logic rstN,
	input  logic run,
	input  logic imemWe,
	input  logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr,
	input  logic [`XLEN-1:0] imemData,
	output logic wbValid,
	output logic [4:0] wbReg,
	output logic [`XLEN-1:0] wbData,
	output logic memWrValid,
	output logic [`XLEN-1:0] memWrAddr,
	output logic [`XLEN-1:0] memWrData
);

	// Fetch/decode
	logic [`XLEN-1:0] instrD, pcPlus4D;
	logic validD;
	// Redirects and stall
	logic stall, jumpTaken, branchTaken;
	logic [`XLEN-1:0] jumpTarget, branchTarget;
	// Decode/execute
	logic regDstE, aluSrcE, memToRegE, regWriteE, memReadE, memWriteE, branchE, validE;
	mipsPkg::aluOpT aluOpE;
	logic [`XLEN-1:0] rsDataE, rtDataE, immE, pcPlus4E;
	logic [4:0] rsE, rtE, rdE;
	logic [5:0] functE;
	// Execute/memory
	logic validM, regWriteM, memToRegM, memReadM, memWriteM;
	logic [`XLEN-1:0] aluResultM, storeDataM;
	logic [4:0] writeRegM;
	// Forward path from memory stage
	logic fwdMemValid;
	logic [4:0] fwdMemReg;
	logic [`XLEN-1:0] fwdMemData;

	fetchStage fetchStage_inst (.*);

	decodeStage decodeStage_inst (.*);

	executeStage executeStage_inst (.*);

	memStage memStage_inst (.*);

endmodule

//--- testbench/mipsCore_props.sv
module mipsCore_props (
	input logic clk,
	input logic rstN,
	input logic wbValid,
	input logic [4:0] wbReg,
	input logic branchTaken,
	input logic validE,
	input logic memWrValid,
	input logic memReadM,
	input logic validM
);

	timeunit 1ns;
	timeprecision 1ps;

	// r0 writes are dropped before the trace
	wbNotR0: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbReg != 5'd0)
		else $error("write-back trace raised for register 0");

	// Squashed slots never redirect
	branchOnValid: assert property (@(posedge clk) disable iff (!rstN) branchTaken |-> validE)
		else $error("bne taken from an empty execute slot");

	loadStoreApart: assert property (@(posedge clk) disable iff (!rstN)
		!(memWrValid && validM && memReadM))
		else $error("store and load in the memory stage at once");

endmodule

////////////////////////////////////////////////////////////////////
// Attach to the stages
////////////////////////////////////////////////////////////////////

bind executeStage mipsCore_props execProps (
	.clk(clk),
	.rstN(rstN),
	.wbValid(wbValid),
	.wbReg(wbReg),
	.branchTaken(branchTaken),
	.validE(validE),
	.memWrValid(1'b0),	// No store trace here
	.memReadM(memReadM),
	.validM(validM)
);

bind memStage mipsCore_props memProps (
	.clk(clk),
	.rstN(rstN),
	.wbValid(wbValid),
	.wbReg(wbReg),
	.branchTaken(1'b0),
	.validE(1'b0),
	.memWrValid(memWrValid),
	.memReadM(memReadM),
	.validM(validM)
);

//--- testbench/mipsCore_tb.sv
`include "mips_cfg.svh"

module mipsCore_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ImemAw = $clog2(`IMEM_DEPTH);
	localparam int TokW = 8 * 32;	// Longest token in the data file
	localparam int MaxEvents = 32;
	localparam int EventTimeout = 200;	// Cycles until all traces seen
	localparam int DrainCycles = 16;	// Quiet window after the last event

	logic clk;
	logic rstN;
	logic run;
	logic imemWe;
	logic [ImemAw-1:0] imemAddr;
	logic [`XLEN-1:0] imemData;
	logic wbValid;
	logic [4:0] wbReg;
	logic [`XLEN-1:0] wbData;
	logic memWrValid;
	logic [`XLEN-1:0] memWrAddr;
	logic [`XLEN-1:0] memWrData;

	// Current test, filled from the data file
	logic [TokW-1:0] testName;
	logic [`XLEN-1:0] prog [`IMEM_DEPTH];
	logic [4:0] expWbReg [MaxEvents];
	logic [`XLEN-1:0] expWbData [MaxEvents];
	logic [`XLEN-1:0] expStAddr [MaxEvents];
	logic [`XLEN-1:0] expStData [MaxEvents];
	int progLen, wbLen, stLen;
	int testErrors, testsRun, testsFailed, setupErrors;

	mipsCore mipsCore_inst (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.memWrValid(memWrValid),
		.memWrAddr(memWrAddr),
		.memWrData(memWrData)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;	// 4 ns period

	task automatic applyReset();
		@(negedge clk);
		rstN = 1'b0;
		run  = 1'b0;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
	endtask

	// Whole memory written, tail filled with zero words (no-ops)
	task automatic loadProgram();
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			@(negedge clk);
			imemWe   = 1'b1;
			imemAddr = ImemAw'(i);
			imemData = (i < progLen) ? prog[i] : '0;
		end
		@(negedge clk);
		imemWe = 1'b0;
	endtask

	// One cycle of both trace ports, compared in program order
	task automatic sampleTraces(inout int wbIdx, inout int stIdx);
		if (wbValid) begin
			if (wbIdx >= wbLen) begin
				$display("%0s: unexpected write-back to r%0d", testName, wbReg);
				testErrors++;
			end else begin
				if (wbReg !== expWbReg[wbIdx]) begin
					$display("CHECK FAILED wbReg expected %h got %h", expWbReg[wbIdx], wbReg);
					testErrors++;
				end
				if (wbData !== expWbData[wbIdx]) begin
					$display("CHECK FAILED wbData expected %h got %h", expWbData[wbIdx], wbData);
					testErrors++;
				end
				wbIdx++;
			end
		end
		if (memWrValid) begin
			if (stIdx >= stLen) begin
				$display("%0s: unexpected store to address %h", testName, memWrAddr);
				testErrors++;
			end else begin
				if (memWrAddr !== expStAddr[stIdx]) begin
					$display("CHECK FAILED memWrAddr expected %h got %h", expStAddr[stIdx], memWrAddr);
					testErrors++;
				end
				if (memWrData !== expStData[stIdx]) begin
					$display("CHECK FAILED memWrData expected %h got %h", expStData[stIdx], memWrData);
					testErrors++;
				end
				stIdx++;
			end
		end
	endtask

	task automatic runTest();
		int wbIdx;
		int stIdx;
		int cycles;
		wbIdx = 0;
		stIdx = 0;
		cycles = 0;
		testErrors = 0;
		applyReset();
		loadProgram();
		run = 1'b1;
		while ((wbIdx < wbLen || stIdx < stLen) && cycles < EventTimeout) begin
			@(negedge clk);	// Outputs settled since the rising edge
			cycles++;
			sampleTraces(wbIdx, stIdx);
		end
		if (wbIdx < wbLen || stIdx < stLen) begin
			$display("%0s: timed out, saw %0d of %0d write-backs and %0d of %0d stores",
				testName, wbIdx, wbLen, stIdx, stLen);
			testErrors++;
		end else begin
			repeat (DrainCycles) begin	// Squashed instrs must stay silent
				@(negedge clk);
				sampleTraces(wbIdx, stIdx);
			end
		end
		run = 1'b0;
		testsRun++;
		if (testErrors != 0)
			testsFailed++;
		$display("%0s: %0s with %0d errors", testName, (testErrors == 0) ? "passed" : "failed",
			testErrors);
	endtask

	initial begin
		int fd;
		int code;
		int count;
		bit done;
		logic [TokW-1:0] tok;
		logic [8*128-1:0] lineBuf;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		rstN = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		testsRun = 0;
		testsFailed = 0;
		setupErrors = 0;
		done = 1'b0;
		fd = $fopen("testbench/core_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/core_tests.txt");
			setupErrors++;
			done = 1'b1;
		end
		while (!done) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) begin
				done = 1'b1;	// End of file
			end else if (tok == TokW'("#")) begin
				code = $fgets(lineBuf, fd);
			end else if (tok == TokW'("test")) begin
				code = $fscanf(fd, "%s", testName);
				progLen = 0;
				wbLen = 0;
				stLen = 0;
			end else if (tok == TokW'("prog")) begin
				code = $fscanf(fd, "%d", count);
				repeat (count) begin
					code = $fscanf(fd, "%h", a);
					prog[progLen] = a;
					progLen++;
				end
			end else if (tok == TokW'("wb")) begin
				code = $fscanf(fd, "%d", count);
				repeat (count) begin
					code = $fscanf(fd, "%h %h", a, b);	// Register, value
					expWbReg[wbLen] = a[4:0];
					expWbData[wbLen] = b;
					wbLen++;
				end
			end else if (tok == TokW'("st")) begin
				code = $fscanf(fd, "%d", count);
				repeat (count) begin
					code = $fscanf(fd, "%h %h", a, b);	// Byte address, data
					expStAddr[stLen] = a;
					expStData[stLen] = b;
					stLen++;
				end
			end else if (tok == TokW'("end")) begin
				runTest();
			end else begin
				$display("unknown keyword %0s in the test file", tok);
				setupErrors++;
				done = 1'b1;
			end
		end
		if (fd != 0)
			$fclose(fd);
		$display("%0d tests run, %0d passed, %0d failed", testsRun, testsRun - testsFailed,
			testsFailed);
		if (setupErrors == 0 && testsFailed == 0 && testsRun > 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/core_tests.txt
# test <name>, then lines <kind> <count> <hex items>, each test closed by end
# prog: instruction words; wb: register and value pairs; st: byte address and data pairs
# ALU and addi, each program ends in a jump to itself
test alu
prog 9 20010005 2002fffd 00221820 00222022 00222824 00223025 0041382a 0022402a 08000008
wb 4 1 5 2 fffffffd 3 2 4 8
wb 4 5 5 6 fffffffd 7 1 8 0
end
# Stores with positive and negative offset, loaded back
test mem
prog 7 20010010 20021234 ac220004 ac21fffc 8c230004 8c24fffc 08000006
wb 4 1 10 2 1234 3 1234 4 10
st 2 14 1234 c 10
end
# Back-to-back dependencies and a load-use pair
test fwd_load_use
prog 8 20010007 00211020 00411820 ac030000 8c040000 00842820 00a33022 08000007
wb 6 1 7 2 e 3 15 4 15 5 2a 6 15
st 1 0 15
end
# Taken bne skips two, not-taken bne falls through
test branch
prog 9 20010001 20020002 14220002 20030003 20040004 14210001 20050005 20060006 08000008
wb 4 1 1 2 2 5 5 6 6
end
# j skips its successor
test jump
prog 6 20010001 08000003 20020002 20030003 ac030008 08000005
wb 2 1 1 3 3
st 1 8 3
end
# Unknown opcode and writes to r0 stay silent
test unknown_r0
prog 7 20010009 fc21ffff 20200005 00210020 20220001 00021820 08000006
wb 3 1 9 2 a 3 a
end

//--- src.f
+incdir+common
common/mipsPkg.sv
control/mainControl.sv
control/aluControl.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/mipsCore.sv
testbench/mipsCore_props.sv
testbench/mipsCore_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP = mipsCore_tb
FILELIST = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
